// ==== verilog/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

  // Command opcodes, upper nibble of the first command byte
  localparam logic [3:0] OP_SET   = 4'd1;
  localparam logic [3:0] OP_GET   = 4'd2;
  localparam logic [3:0] OP_QUERY = 4'd3;

  // Response status, upper nibble of the first response byte
  localparam logic [3:0] ST_OK     = 4'd0;
  localparam logic [3:0] ST_BUSERR = 4'd1;
  localparam logic [3:0] ST_BADCMD = 4'd2;
  localparam logic [3:0] ST_BADLEN = 4'd3;
  localparam logic [3:0] ST_BADARG = 4'd4;

  // Packet size, same for commands and responses
  localparam int CMD_BYTES = 4;
  localparam int LEN_W     = $clog2(CMD_BYTES + 1);  // Byte counter, saturates
  localparam int BYTE_IW   = $clog2(CMD_BYTES);      // Byte index in a response

  // Register bus
  localparam int ADR_W = 8;
  localparam int DAT_W = 16;

  // Device information for QUERY
  localparam logic [15:0] QUERY_DEVICE_ID = 16'hA5C3;
  localparam logic [15:0] QUERY_VERSION   = 16'h0100;

  // Response FIFO
  localparam int RESP_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(RESP_DEPTH);
  localparam int FIFO_CW    = $clog2(RESP_DEPTH + 1);

  // Command engine FSM
  localparam logic [1:0] ENG_RECV = 2'd0;  // Taking packet bytes
  localparam logic [1:0] ENG_BUS  = 2'd1;  // Wishbone transfer in flight
  localparam logic [1:0] ENG_PUSH = 2'd2;  // Response ready for the FIFO

endpackage

`default_nettype wire

// ==== verilog/mmio_cmd_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmio_cmd_engine (
  input  wire                        clock,
  input  wire                        reset,

  input  wire                        usb_tvalid_i,
  output logic                       usb_tready_o,
  input  wire                        usb_tlast_i,
  input  wire  [7:0]                 usb_tdata_i,

  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [mmio_pkg::ADR_W-1:0] wb_adr_o,
  output logic [mmio_pkg::DAT_W-1:0] wb_dat_o,
  input  wire  [mmio_pkg::DAT_W-1:0] wb_dat_i,
  input  wire                        wb_ack_i,
  input  wire                        wb_err_i,

  output logic                       resp_push_o,
  output logic [31:0]                resp_word_o,
  input  wire                        resp_full_i
);
  import mmio_pkg::*;

  logic [1:0]       state_q;
  logic [LEN_W-1:0] cnt_q;    // Bytes taken so far in this packet
  logic [23:0]      shift_q;
  logic [3:0]       tag_q;
  logic [31:0]      resp_q;

  logic             rx_w;
  logic             last_w;
  logic             len_ok_w;
  logic             is_bus_w;
  logic [31:0]      pkt_w;
  logic [3:0]       op_w;
  logic [3:0]       tag_w;
  logic [ADR_W-1:0] arg_w;
  logic [DAT_W-1:0] val_w;
  logic [3:0]       dec_st_w;
  logic [DAT_W-1:0] dec_dat_w;
  logic [DAT_W-1:0] rd_dat_w;

  assign rx_w     = usb_tvalid_i && usb_tready_o;
  assign last_w   = rx_w && usb_tlast_i;
  assign pkt_w    = {shift_q, usb_tdata_i};  // Whole packet on its last byte
  assign op_w     = pkt_w[31:28];
  assign arg_w    = pkt_w[23:16];
  assign val_w    = pkt_w[15:0];
  assign tag_w    = (cnt_q == '0) ? usb_tdata_i[3:0] : tag_q;
  assign len_ok_w = (cnt_q == LEN_W'(CMD_BYTES - 1));
  assign is_bus_w = len_ok_w && (op_w == OP_SET || op_w == OP_GET);

  // Writes and failed transfers return no data
  assign rd_dat_w = (wb_err_i || wb_we_o) ? {DAT_W{1'b0}} : wb_dat_i;

  assign resp_push_o = (state_q == ENG_PUSH) && !resp_full_i;
  assign resp_word_o = resp_q;

  // Status and data for everything answered without the bus
  always_comb begin
    dec_st_w  = ST_OK;
    dec_dat_w = '0;
    if (!len_ok_w) begin
      dec_st_w = ST_BADLEN;
    end else begin
      case (op_w)
        OP_SET, OP_GET: dec_st_w = ST_OK;  // Status comes from the bus
        OP_QUERY: begin
          case (arg_w)
            8'd0:    dec_dat_w = QUERY_DEVICE_ID;
            8'd1:    dec_dat_w = QUERY_VERSION;
            8'd2:    dec_dat_w = DAT_W'(RESP_DEPTH);
            default: dec_st_w  = ST_BADARG;
          endcase
        end
        default: dec_st_w = ST_BADCMD;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= ENG_RECV;
      cnt_q        <= '0;
      usb_tready_o <= 1'b0;
      wb_cyc_o     <= 1'b0;
      wb_stb_o     <= 1'b0;
    end else begin
      case (state_q)
        ENG_RECV: begin
          usb_tready_o <= 1'b1;
          if (rx_w) begin
            if (usb_tlast_i) begin
              cnt_q        <= '0;
              usb_tready_o <= 1'b0;  // Closed until the response is queued
              if (is_bus_w) begin
                state_q  <= ENG_BUS;
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
              end else begin
                state_q <= ENG_PUSH;
              end
            end else if (cnt_q != LEN_W'(CMD_BYTES)) begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        ENG_BUS: begin
          if (wb_ack_i || wb_err_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            state_q  <= ENG_PUSH;
          end
        end
        ENG_PUSH: begin
          if (!resp_full_i) begin
            state_q      <= ENG_RECV;
            usb_tready_o <= 1'b1;
          end
        end
        default: state_q <= ENG_RECV;
      endcase
    end
  end

  // Packet bytes, bus request and response word
  always_ff @(posedge clock) begin
    if (rx_w) begin
      shift_q <= pkt_w[23:0];
      if (cnt_q == '0) tag_q <= usb_tdata_i[3:0];
    end
    if (last_w) begin
      wb_we_o  <= (op_w == OP_SET);
      wb_adr_o <= arg_w;
      wb_dat_o <= val_w;
      resp_q   <= {dec_st_w, tag_w, 8'h00, dec_dat_w};
    end else if (state_q == ENG_BUS && (wb_ack_i || wb_err_i)) begin
      resp_q <= {(wb_err_i ? ST_BUSERR : ST_OK), tag_q, 8'h00, rd_dat_w};
    end
  end

  a_stb_in_cyc : assert property (@(posedge clock) disable iff (reset)
    wb_stb_o |-> wb_cyc_o);

  // Request held until the slave answers
  a_bus_stable : assert property (@(posedge clock) disable iff (reset)
    wb_stb_o && !wb_ack_i && !wb_err_i |=>
      wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_we_o));

endmodule

`default_nettype wire

// ==== verilog/mmio_resp_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmio_resp_fifo (
  input  wire         clock,
  input  wire         reset,

  input  wire         push_i,
  input  wire  [31:0] word_i,
  output logic        full_o,

  input  wire         pop_i,
  output logic [31:0] word_o,
  output logic        valid_o
);
  import mmio_pkg::*;

  logic [31:0]        mem_q [RESP_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_CW-1:0] count_q;

  logic               wr_en_w;
  logic               rd_en_w;

  assign full_o  = (count_q == FIFO_CW'(RESP_DEPTH));
  assign valid_o = (count_q != '0);
  assign word_o  = mem_q[rd_ptr_q];  // Head word, shown as soon as written

  assign wr_en_w = push_i && !full_o;
  assign rd_en_w = pop_i && valid_o;

  always_ff @(posedge clock) begin
    if (wr_en_w) mem_q[wr_ptr_q] <= word_i;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en_w) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_AW'(RESP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en_w) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_AW'(RESP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en_w, rd_en_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // The engine must respect full, the sender must respect valid
  a_no_push_full : assert property (@(posedge clock) disable iff (reset)
    push_i |-> !full_o);

  a_no_pop_empty : assert property (@(posedge clock) disable iff (reset)
    pop_i |-> valid_o);

endmodule

`default_nettype wire

// ==== verilog/mmio_resp_sender.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmio_resp_sender (
  input  wire         clock,
  input  wire         reset,

  input  wire  [31:0] word_i,
  input  wire         valid_i,
  output logic        pop_o,

  output logic        usb_tvalid_o,
  output logic        usb_tlast_o,
  output logic [7:0]  usb_tdata_o,
  input  wire         usb_tready_i
);
  import mmio_pkg::*;

  logic [31:0]        word_q;  // Remaining bytes, next one on top
  logic [BYTE_IW-1:0] idx_q;
  logic               tx_w;
  logic               end_w;

  assign tx_w  = usb_tvalid_o && usb_tready_i;
  assign end_w = (idx_q == BYTE_IW'(CMD_BYTES - 1));

  // Take a new word only between packets
  assign pop_o = valid_i && !usb_tvalid_o;

  assign usb_tdata_o = word_q[31:24];
  assign usb_tlast_o = end_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      usb_tvalid_o <= 1'b0;
      idx_q        <= '0;
    end else if (pop_o) begin
      usb_tvalid_o <= 1'b1;
      idx_q        <= '0;
    end else if (tx_w) begin
      idx_q <= idx_q + 1'b1;
      if (end_w) usb_tvalid_o <= 1'b0;  // Packet done, pop again next cycle
    end
  end

  always_ff @(posedge clock) begin
    if (pop_o) begin
      word_q <= word_i;
    end else if (tx_w) begin
      word_q <= {word_q[23:0], 8'h00};
    end
  end

  // Stalled byte must not change under the host
  a_out_stable : assert property (@(posedge clock) disable iff (reset)
    usb_tvalid_o && !usb_tready_i |=>
      usb_tvalid_o && $stable(usb_tdata_o) && $stable(usb_tlast_o));

endmodule

`default_nettype wire

// ==== verilog/usb_mmio.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_mmio (
  input  wire                        clock,
  input  wire                        reset,

  // Command packets from the bulk-out endpoint
  input  wire                        usb_tvalid_i,
  output logic                       usb_tready_o,
  input  wire                        usb_tlast_i,
  input  wire  [7:0]                 usb_tdata_i,

  // Response packets toward the bulk-in endpoint
  output logic                       usb_tvalid_o,
  input  wire                        usb_tready_i,
  output logic                       usb_tlast_o,
  output logic [7:0]                 usb_tdata_o,

  // Wishbone classic master
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [mmio_pkg::ADR_W-1:0] wb_adr_o,
  output logic [mmio_pkg::DAT_W-1:0] wb_dat_o,
  input  wire  [mmio_pkg::DAT_W-1:0] wb_dat_i,
  input  wire                        wb_ack_i,
  input  wire                        wb_err_i
);

  logic        resp_push;
  logic        resp_full;
  logic [31:0] resp_word;
  logic [31:0] fifo_word;
  logic        fifo_valid;
  logic        fifo_pop;

  mmio_cmd_engine u_engine (
    .clock        (clock),
    .reset        (reset),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tready_o (usb_tready_o),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i),
    .resp_push_o  (resp_push),
    .resp_word_o  (resp_word),
    .resp_full_i  (resp_full)
  );

  // Lets commands keep flowing while the host stalls responses
  mmio_resp_fifo u_fifo (
    .clock   (clock),
    .reset   (reset),
    .push_i  (resp_push),
    .word_i  (resp_word),
    .full_o  (resp_full),
    .pop_i   (fifo_pop),
    .word_o  (fifo_word),
    .valid_o (fifo_valid)
  );

  mmio_resp_sender u_sender (
    .clock        (clock),
    .reset        (reset),
    .word_i       (fifo_word),
    .valid_i      (fifo_valid),
    .pop_o        (fifo_pop),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o),
    .usb_tready_i (usb_tready_i)
  );

endmodule

`default_nettype wire

// ==== tb/mmio_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmio_checker #(
  parameter logic [7:0] ERR_BASE = 8'hF0
) (
  input  wire                        clock,
  input  wire                        reset,

  // Command stream into the DUT
  input  wire                        cmd_valid_i,
  input  wire                        cmd_ready_i,
  input  wire                        cmd_last_i,
  input  wire  [7:0]                 cmd_data_i,

  // Response stream out of the DUT
  input  wire                        rsp_valid_i,
  input  wire                        rsp_ready_i,
  input  wire                        rsp_last_i,
  input  wire  [7:0]                 rsp_data_i,

  // Wishbone master side of the DUT
  input  wire                        wb_cyc_i,
  input  wire                        wb_stb_i,
  input  wire                        wb_we_i,
  input  wire  [mmio_pkg::ADR_W-1:0] wb_adr_i,
  input  wire  [mmio_pkg::DAT_W-1:0] wb_wdat_i,
  input  wire                        wb_ack_i,
  input  wire                        wb_err_i,

  output int                         value_errs_o,
  output int                         proto_errs_o,
  output int                         resp_count_o
);
  import mmio_pkg::*;

  logic [DAT_W-1:0]     model [256];  // Same fill as the slave memory
  logic [7:0]           pkt [8];
  int                   pkt_len;
  int                   out_idx;      // Byte position in the current response
  logic                 ready_off;    // Last command byte taken on the previous edge
  logic [31:0]          exp_q [$];
  logic [ADR_W+DAT_W:0] bus_q [$];    // {we, adr, dat}

  initial begin
    int a;
    for (a = 0; a < 256; a++) model[a] = {8'(a), ~8'(a)};
    pkt_len      = 0;
    out_idx      = 0;
    ready_off    = 1'b0;
    value_errs_o = 0;
    proto_errs_o = 0;
    resp_count_o = 0;
  end

  // Expected response and bus transfer for one finished command packet
  task automatic predict_command();
    logic [3:0]       op;
    logic [3:0]       tag;
    logic [3:0]       st;
    logic [7:0]       arg;
    logic [DAT_W-1:0] val;
    logic [DAT_W-1:0] dat;
    op  = pkt[0][7:4];
    tag = pkt[0][3:0];
    arg = pkt[1];
    val = {pkt[2], pkt[3]};
    st  = ST_OK;
    dat = '0;
    if (pkt_len != CMD_BYTES) begin
      st = ST_BADLEN;
    end else if (op == OP_SET || op == OP_GET) begin
      bus_q.push_back({op == OP_SET, arg, val});
      if (arg >= ERR_BASE) st = ST_BUSERR;
      else if (op == OP_SET) model[arg] = val;
      else dat = model[arg];
    end else if (op == OP_QUERY) begin
      case (arg)
        8'd0:    dat = QUERY_DEVICE_ID;
        8'd1:    dat = QUERY_VERSION;
        8'd2:    dat = DAT_W'(RESP_DEPTH);
        default: st  = ST_BADARG;
      endcase
    end else begin
      st = ST_BADCMD;
    end
    exp_q.push_back({st, tag, 8'h00, dat});
  endtask

  task automatic check_out_byte();
    logic [31:0] word;
    logic [7:0]  want_byte;
    logic        want_last;
    if (exp_q.size() == 0) begin
      proto_errs_o++;
      $display("Response byte 0x%02h came out with no command outstanding", rsp_data_i);
    end else begin
      word      = exp_q[0];
      want_byte = word[8 * (CMD_BYTES - 1 - out_idx) +: 8];  // MSB first
      want_last = (out_idx == CMD_BYTES - 1);
      if (rsp_data_i !== want_byte) begin
        value_errs_o++;
        $display("CHECK FAILED usb_tdata_o: expected 0x%02h, got 0x%02h (response %0d byte %0d)",
                 want_byte, rsp_data_i, resp_count_o, out_idx);
      end
      if (rsp_last_i !== want_last) begin
        value_errs_o++;
        $display("CHECK FAILED usb_tlast_o: expected 0x%0h, got 0x%0h (response %0d byte %0d)",
                 want_last, rsp_last_i, resp_count_o, out_idx);
      end
      if (want_last) begin
        void'(exp_q.pop_front());
        resp_count_o++;
        out_idx = 0;
      end else begin
        out_idx++;
      end
    end
  endtask

  task automatic check_bus_transfer();
    logic [ADR_W+DAT_W:0] want;
    if (bus_q.size() == 0) begin
      proto_errs_o++;
      $display("Wishbone transfer at address 0x%02h with no SET or GET pending", wb_adr_i);
    end else begin
      want = bus_q.pop_front();
      if (wb_we_i !== want[ADR_W+DAT_W]) begin
        value_errs_o++;
        $display("CHECK FAILED wb_we_o: expected 0x%0h, got 0x%0h", want[ADR_W+DAT_W], wb_we_i);
      end
      if (wb_adr_i !== want[DAT_W +: ADR_W]) begin
        value_errs_o++;
        $display("CHECK FAILED wb_adr_o: expected 0x%02h, got 0x%02h",
                 want[DAT_W +: ADR_W], wb_adr_i);
      end
      if (wb_wdat_i !== want[DAT_W-1:0]) begin
        value_errs_o++;
        $display("CHECK FAILED wb_dat_o: expected 0x%04h, got 0x%04h", want[DAT_W-1:0], wb_wdat_i);
      end
    end
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      // Input stays closed right after a packet and during its bus transfer
      if ((ready_off || wb_cyc_i) && cmd_ready_i !== 1'b0) begin
        value_errs_o++;
        $display("CHECK FAILED usb_tready_o: expected 0x0, got 0x%0h", cmd_ready_i);
      end
      ready_off = cmd_valid_i && cmd_ready_i && cmd_last_i;
      if (cmd_valid_i && cmd_ready_i) begin
        if (pkt_len < 8) pkt[pkt_len] = cmd_data_i;
        pkt_len++;
        if (cmd_last_i) begin
          predict_command();
          pkt_len = 0;
        end
      end
      if (rsp_valid_i && rsp_ready_i) check_out_byte();
      if (wb_cyc_i && wb_stb_i && (wb_ack_i || wb_err_i)) check_bus_transfer();  // Transfer ends
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_usb_mmio.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_usb_mmio;
  import mmio_pkg::*;

  localparam int         N_ROWS         = 21;
  localparam int         TIMEOUT_CYCLES = N_ROWS * 60 + 200;
  localparam int         STALL_FIRST    = 15;  // Rows sent with the output stream held off
  localparam int         STALL_LAST     = 20;
  localparam logic [7:0] WB_ERR_BASE    = 8'hF0;

  logic             clock;
  logic             reset;
  logic             cmd_valid, cmd_ready, cmd_last;
  logic [7:0]       cmd_data;
  logic             rsp_valid, rsp_ready, rsp_last;
  logic [7:0]       rsp_data;
  logic             wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [ADR_W-1:0] wb_adr;
  logic [DAT_W-1:0] wb_dat_w;
  logic [DAT_W-1:0] wb_dat_r;

  int               seed = 67505;
  logic             stall_out;
  int               wait_left;
  int               cycles;
  int               value_errs, proto_errs, resp_count;
  logic [DAT_W-1:0] wb_mem [256];

  // Command bytes left aligned, packet length, idle cycles before the packet
  logic [39:0]      tbl_cmd [N_ROWS];
  int               tbl_len [N_ROWS];
  int               tbl_gap [N_ROWS];
  int               n_added;

  usb_mmio DUT (
    .clock(clock), .reset(reset),
    .usb_tvalid_i(cmd_valid), .usb_tready_o(cmd_ready),
    .usb_tlast_i(cmd_last), .usb_tdata_i(cmd_data),
    .usb_tvalid_o(rsp_valid), .usb_tready_i(rsp_ready),
    .usb_tlast_o(rsp_last), .usb_tdata_o(rsp_data),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack), .wb_err_i(wb_err)
  );

  mmio_checker #(.ERR_BASE(WB_ERR_BASE)) CHK (
    .clock(clock), .reset(reset),
    .cmd_valid_i(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_last_i(cmd_last), .cmd_data_i(cmd_data),
    .rsp_valid_i(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_last_i(rsp_last), .rsp_data_i(rsp_data),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_wdat_i(wb_dat_w), .wb_ack_i(wb_ack), .wb_err_i(wb_err),
    .value_errs_o(value_errs), .proto_errs_o(proto_errs), .resp_count_o(resp_count)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic add_row(input logic [39:0] bytes, input int len, input int gap);
    tbl_cmd[n_added] = bytes;
    tbl_len[n_added] = len;
    tbl_gap[n_added] = gap;
    n_added++;
  endtask

  // Called on a falling edge, returns on the falling edge after the last byte
  task automatic send_packet(input int row);
    int b;
    repeat (tbl_gap[row]) @(negedge clock);
    for (b = 0; b < tbl_len[row]; b++) begin
      if (($random(seed) & 3) == 0) begin
        cmd_valid = 1'b0;
        @(negedge clock);
      end
      cmd_valid = 1'b1;
      cmd_data  = tbl_cmd[row][39 - 8 * b -: 8];
      cmd_last  = (b == tbl_len[row] - 1);
      while (!cmd_ready) @(negedge clock);  // Ready only changes at rising edges
      @(negedge clock);
    end
    cmd_valid = 1'b0;
    cmd_last  = 1'b0;
  endtask

  // Wishbone slave, 0 to 3 wait states
  always @(negedge clock) begin
    if (reset) begin
      wb_ack = 1'b0;
      wb_err = 1'b0;
    end else if (wb_ack || wb_err) begin
      wb_ack    = 1'b0;
      wb_err    = 1'b0;
      wait_left = $random(seed) & 3;
    end else if (wb_cyc && wb_stb) begin
      if (wait_left > 0) begin
        wait_left--;
      end else if (wb_adr >= WB_ERR_BASE) begin
        wb_err = 1'b1;
      end else begin
        wb_ack = 1'b1;
        if (wb_we) wb_mem[wb_adr] = wb_dat_w;
        wb_dat_r = wb_mem[wb_adr];
      end
    end
  end

  always @(negedge clock) begin
    if (stall_out) rsp_ready = 1'b0;
    else rsp_ready = (($random(seed) & 3) != 0);  // Host takes about 3 of 4
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d of %0d responses received",
                 cycles, resp_count, N_ROWS);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  initial begin
    int i;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_last  = 1'b0;
    cmd_data  = 8'h00;
    rsp_ready = 1'b0;
    wb_ack    = 1'b0;
    wb_err    = 1'b0;
    wb_dat_r  = '0;
    stall_out = 1'b0;
    wait_left = 0;
    for (i = 0; i < 256; i++) wb_mem[i] = {8'(i), ~8'(i)};
    n_added = 0;
    add_row(40'h11_10_12_34_00, 4, 0);  // SET then GET of 0x10
    add_row(40'h22_10_00_00_00, 4, 2);
    add_row(40'h13_20_BE_EF_00, 4, 0);
    add_row(40'h24_20_00_00_00, 4, 1);
    add_row(40'h25_30_00_00_00, 4, 3);  // Never written
    add_row(40'h16_F0_55_AA_00, 4, 0);  // Error region
    add_row(40'h27_FF_00_00_00, 4, 0);
    add_row(40'h38_00_00_00_00, 4, 5);  // QUERY indexes 0, 1, 2, 5
    add_row(40'h39_01_00_00_00, 4, 0);
    add_row(40'h3A_02_00_00_00, 4, 0);
    add_row(40'h3B_05_00_00_00, 4, 0);
    add_row(40'h7C_00_00_00_00, 4, 2);  // Unknown opcode
    add_row(40'h1D_40_00_00_00, 3, 0);  // Short and long packets
    add_row(40'h1E_40_00_11_22, 5, 0);
    add_row(40'h2F_10_00_00_00, 4, 0);
    add_row(40'h10_40_0A_0B_00, 4, 0);
    add_row(40'h21_40_00_00_00, 4, 0);
    add_row(40'h32_00_00_00_00, 4, 0);
    add_row(40'h13_41_55_55_00, 4, 0);
    add_row(40'h24_41_00_00_00, 4, 0);
    add_row(40'h35_01_00_00_00, 4, 0);

    repeat (5) @(negedge clock);
    reset = 1'b0;

    for (i = 0; i < N_ROWS; i++) begin
      if (i == STALL_FIRST) begin
        while (resp_count != i) @(negedge clock);  // Start the stall with an empty FIFO
        stall_out = 1'b1;
      end
      send_packet(i);
      if (i == STALL_LAST) begin
        repeat (40) @(negedge clock);
        stall_out = 1'b0;
      end
    end

    while (resp_count != N_ROWS) @(negedge clock);
    repeat (10) @(negedge clock);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/mmio_pkg.sv
verilog/mmio_cmd_engine.sv
verilog/mmio_resp_fifo.sv
verilog/mmio_resp_sender.sv
verilog/usb_mmio.sv
tb/mmio_checker.sv
tb/tb_usb_mmio.sv
